//--- compile.f
+incdir+.
fetch_pkg.sv
fetch_predecode.sv
fetch_pc_ctrl.sv
fetch_size_queue.sv
fetch_unit.sv
tb_fetch_mem.sv
tb_fetch.sv

//--- Makefile
# Verilator build and run for the fetch unit testbench.

VERILATOR ?= verilator
TOP       ?= tb_fetch
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SRCS := fetch_macros.svh fetch_pkg.sv fetch_predecode.sv fetch_pc_ctrl.sv \
        fetch_size_queue.sv fetch_unit.sv tb_fetch_mem.sv tb_fetch.sv

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) compile.f
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_fetch.sv
`default_nettype none
`timescale 1ns/1ns

`include "fetch_macros.svh"

module tb_fetch
    import fetch_pkg::*;
;

    localparam int K_PLAIN  = 0;
    localparam int K_BRANCH = 1;
    localparam int K_JUMP   = 2;
    localparam int K_HALT   = 3;
    localparam int LIMIT    = 400;

    logic  clk, rst, mem_req, mem_valid, lsb_full, iq_full;
    logic  branch_taken, branch_not_taken, jalr_ready, pc_ready;
    logic  inst_valid, flush;
    addr_t mem_addr, branch_pc, jalr_addr, nxt_pc, inst_pc, commit_pc;
    word_t mem_data, instruction;

    // model of the fetch stream and the committed program counter.
    addr_t     exp_pc, model_commit, pred_next;
    logic      halted, prev_bnt, prev_stall, prev_mem_valid, pred_long;
    int        n_deliv, pred_kind;
    addr_t     q_next [$];
    inst_len_t q_len [$];
    int        q_kind [$];

    fetch_unit u_fetch_unit (
        .clk(clk), .rst(rst), .mem_valid(mem_valid), .mem_data(mem_data),
        .lsb_full(lsb_full), .iq_full(iq_full), .branch_taken(branch_taken),
        .branch_pc(branch_pc), .branch_not_taken(branch_not_taken),
        .jalr_ready(jalr_ready), .jalr_addr(jalr_addr), .pc_ready(pc_ready),
        .nxt_pc(nxt_pc), .mem_req(mem_req), .mem_addr(mem_addr),
        .instruction(instruction), .inst_valid(inst_valid), .inst_pc(inst_pc),
        .flush(flush), .commit_pc(commit_pc)
    );

    tb_fetch_mem u_mem (
        .clk(clk), .rst(rst), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_valid(mem_valid), .mem_data(mem_data)
    );

    always #2 clk = ~clk;

    // ==================================================
    // reference prediction
    // ==================================================

    function automatic addr_t predict_next(input word_t w, input addr_t pc,
                                           output int kind, output logic long_inst);
        addr_t nxt;
        long_inst = (w[1:0] == 2'b11);
        kind      = K_PLAIN;
        nxt       = long_inst ? pc + 32'd4 : pc + 32'd2;
        if (long_inst && w[6:0] == 7'h6f) begin
            kind = K_JUMP;
            nxt  = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end else if (long_inst && w[6:0] == 7'h63) begin
            kind = K_BRANCH;
            nxt  = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end else if (long_inst && w[6:0] == 7'h67) begin
            kind = K_HALT;
        end else if (w[1:0] == 2'b01 && (w[15:13] == 3'b001 || w[15:13] == 3'b101)) begin
            kind = K_JUMP;
            nxt  = pc + {{20{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11],
                         w[5:3], 1'b0};
        end else if (w[1:0] == 2'b01 && w[15:14] == 2'b11) begin
            kind = K_BRANCH;
            nxt  = pc + {{23{w[12]}}, w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0};
        end else if (w[1:0] == 2'b10 && w[15:13] == 3'b100 && w[6:2] == 5'd0 &&
                     w[11:7] != 5'd0) begin
            kind = K_HALT;
        end
        return nxt;
    endfunction

    task automatic stop_with_failure();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t", why, $time);
        stop_with_failure();
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // ==================================================
    // compare process
    // ==================================================

    always @(posedge clk) begin
        if (!rst) begin
            check_eq("commit_pc", commit_pc, model_commit);
            check_eq("flush", {31'd0, flush}, {31'd0, prev_bnt});
            if (mem_req) begin
                if (prev_stall) abort_run("request issued under back-pressure");
                if (halted) abort_run("request issued while waiting for a jump target");
                check_eq("mem_addr", mem_addr, exp_pc);
            end
            if (inst_valid) begin
                if (!prev_mem_valid) abort_run("instruction delivered without a response");
                check_eq("inst_pc", inst_pc, exp_pc);
                check_eq("instruction", instruction, u_mem.word_at(exp_pc));
                pred_next = predict_next(instruction, exp_pc, pred_kind, pred_long);
                q_next.push_back(pred_next);
                q_len.push_back(pred_long);
                q_kind.push_back(pred_kind);
                exp_pc  = pred_next;
                halted  = (pred_kind == K_HALT);
                n_deliv = n_deliv + 1;
            end
            if (branch_taken) begin
                model_commit = branch_pc;
            end else if (jalr_ready) begin
                model_commit = jalr_addr;
                exp_pc       = jalr_addr;
                halted       = 1'b0;
            end else if (pc_ready) begin
                model_commit = (nxt_pc == `FETCH_NO_TARGET) ?
                               model_commit + (q_len[0] ? 32'd4 : 32'd2) : nxt_pc;
            end else if (branch_not_taken) begin
                model_commit = model_commit + (q_len[0] ? 32'd4 : 32'd2);
                exp_pc       = model_commit;
                halted       = 1'b0;
                q_next.delete();
                q_len.delete();
                q_kind.delete();
            end
            if (branch_taken || jalr_ready || pc_ready) begin
                void'(q_next.pop_front());
                void'(q_len.pop_front());
                void'(q_kind.pop_front());
            end
        end
        prev_bnt       = branch_not_taken;
        prev_stall     = lsb_full | iq_full;
        prev_mem_valid = mem_valid;
    end

    // ==================================================
    // back-end stimulus
    // ==================================================

    task automatic wait_halted();
        int n;
        n = 0;
        while (!halted) begin
            @(negedge clk);
            n = n + 1;
            if (n > LIMIT) abort_run("timed out waiting for fetch to stop on a jump");
        end
    endtask

    task automatic resolve_head(input addr_t target);
        @(negedge clk);
        if (q_kind[0] == K_BRANCH) begin
            branch_taken = 1'b1;
            branch_pc    = q_next[0];
        end else begin
            pc_ready = 1'b1;
            nxt_pc   = (q_kind[0] == K_JUMP) ? q_next[0] : target;
        end
        @(negedge clk);
        branch_taken = 1'b0;
        pc_ready     = 1'b0;
    endtask

    task automatic drain_to_halt();
        int n;
        n = 0;
        while (q_kind.size() > 0 && q_kind[0] != K_HALT) begin
            resolve_head(`FETCH_NO_TARGET);
            n = n + 1;
            if (n > LIMIT) abort_run("timed out draining the length queue");
        end
    endtask

    task automatic release_jalr(input addr_t target);
        @(negedge clk);
        jalr_ready = 1'b1;
        jalr_addr  = target;
        @(negedge clk);
        jalr_ready = 1'b0;
    endtask

    initial begin
        int n;
        int held;
        clk = 1'b0;
        rst = 1'b1;
        {lsb_full, iq_full, branch_taken, branch_not_taken, jalr_ready, pc_ready} = '0;
        {branch_pc, jalr_addr, nxt_pc} = '0;
        {exp_pc, model_commit, pred_next} = '0;
        {halted, prev_bnt, prev_stall, prev_mem_valid, pred_long} = '0;
        n_deliv   = 0;
        pred_kind = K_PLAIN;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // straight-line words, then the mixed-length block.
        wait_halted();
        drain_to_halt();
        release_jalr(32'h100);
        wait_halted();
        drain_to_halt();
        release_jalr(32'h200);

        // predicted-taken control flow.
        wait_halted();
        drain_to_halt();
        release_jalr(32'h300);

        // mispredicted branch while the predicted target is in flight.
        n = 0;
        while (q_kind.size() == 0) begin
            @(negedge clk);
            n = n + 1;
            if (n > LIMIT) abort_run("timed out waiting for the branch at 0x300");
        end
        branch_not_taken = 1'b1;
        @(negedge clk);
        branch_not_taken = 1'b0;
        wait_halted();
        drain_to_halt();

        // back-pressure holds the restart.
        @(negedge clk);
        lsb_full = 1'b1;
        held     = n_deliv;
        release_jalr(32'h400);
        repeat (8) @(negedge clk);
        lsb_full = 1'b0;
        iq_full  = 1'b1;
        repeat (6) @(negedge clk);
        check_eq("deliveries under stall", held, n_deliv);
        iq_full = 1'b0;
        wait_halted();
        resolve_head(32'h0000_1234);
        drain_to_halt();
        repeat (4) @(negedge clk);
        check_eq("deliveries", n_deliv, 30);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_fetch_mem.sv
`default_nettype none
`timescale 1ns/1ns

`include "fetch_macros.svh"

module tb_fetch_mem
    import fetch_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  mem_req,
    input  wire addr_t mem_addr,
    output logic       mem_valid,
    output word_t      mem_data
);

    localparam word_t JALR_X1 = 32'h0000_80e7;
    localparam word_t C_JR_X1 = 32'h0000_8082;
    localparam word_t C_NOP   = 32'h0000_0001;

    word_t       image [addr_t];
    logic [31:0] lcg_state;
    logic        busy;
    addr_t       req_addr;
    int          wait_cnt;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Each address reads one whole word; unwritten addresses hold a plain addi.
    function automatic word_t word_at(input addr_t a);
        if (image.exists(a)) begin
            return image[a];
        end
        return {a[31:7] ^ a[24:0], 7'b0010011};
    endfunction

    function automatic word_t enc_jal(input int off);
        logic [20:0] i;
        i = off[20:0];
        return {i[20], i[10:1], i[11], i[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic word_t enc_beq(input int off);
        logic [12:0] i;
        i = off[12:0];
        return {i[12], i[10:5], 5'd0, 5'd0, 3'b000, i[4:1], i[11], 7'b1100011};
    endfunction

    function automatic word_t enc_cj(input int off);
        logic [11:0] i;
        i = off[11:0];
        return {16'h0, 3'b101, i[11], i[4], i[9:8], i[10], i[6], i[7], i[3:1], i[5], 2'b01};
    endfunction

    function automatic word_t enc_cbeqz(input int off);
        logic [8:0] i;
        i = off[8:0];
        return {16'h0, 3'b110, i[8], i[4:3], 3'b000, i[7:6], i[2:1], i[5], 2'b01};
    endfunction

    // ==================================================
    // program image
    // ==================================================

    initial begin
        mem_valid = 1'b0;
        mem_data  = '0;
        busy      = 1'b0;
        req_addr  = '0;
        wait_cnt  = 0;
        lcg_state = 32'd98601;
        image[32'h020] = JALR_X1;
        // mixed lengths ending in a compressed register jump.
        image[32'h100] = C_NOP;
        image[32'h106] = C_NOP;
        image[32'h108] = C_NOP;
        image[32'h10e] = C_JR_X1;
        // taken jumps and branches in both directions.
        image[32'h200] = enc_jal(32'h40);
        image[32'h240] = enc_cj(32'h20);
        image[32'h260] = enc_beq(-32'h40);
        image[32'h220] = enc_cbeqz(-32'h10);
        image[32'h210] = enc_jal(-32'h90);
        image[32'h180] = enc_cbeqz(32'h20);
        image[32'h1a0] = enc_cj(-32'h10);
        image[32'h190] = JALR_X1;
        image[32'h300] = enc_beq(32'h40);
        image[32'h308] = JALR_X1;
        image[32'h408] = C_NOP;
        image[32'h40a] = JALR_X1;
    end

    always @(negedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            mem_valid <= 1'b0;
            if (busy) begin
                if (wait_cnt == 1) begin
                    mem_valid <= 1'b1;
                    mem_data  <= word_at(req_addr);
                    busy      <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
            if (mem_req) begin
                lcg_state = lcg_next(lcg_state);
                busy     <= 1'b1;
                req_addr <= mem_addr;
                wait_cnt <= int'(lcg_state[17:16]) + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- fetch_unit.sv
`default_nettype none
`timescale 1ns/1ns

`include "fetch_macros.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  mem_valid,
    input  word_t mem_data,
    input  logic  lsb_full,
    input  logic  iq_full,
    input  logic  branch_taken,
    input  addr_t branch_pc,
    input  logic  branch_not_taken,
    input  logic  jalr_ready,
    input  addr_t jalr_addr,
    input  logic  pc_ready,
    input  addr_t nxt_pc,
    output logic  mem_req,
    output addr_t mem_addr,
    output word_t instruction,
    output logic  inst_valid,
    output addr_t inst_pc,
    output logic  flush,
    output addr_t commit_pc
);

    word_t     dec_word;
    addr_t     dec_pc;
    inst_len_t is_long;
    addr_t     pred_pc;
    logic      halt;
    logic      push;
    inst_len_t push_len;
    addr_t     fallthrough_pc;

    fetch_pc_ctrl u_pc_ctrl (
        .clk              (clk),
        .rst              (rst),
        .mem_valid        (mem_valid),
        .mem_data         (mem_data),
        .lsb_full         (lsb_full),
        .iq_full          (iq_full),
        .jalr_ready       (jalr_ready),
        .jalr_addr        (jalr_addr),
        .branch_not_taken (branch_not_taken),
        .fallthrough_pc   (fallthrough_pc),
        .is_long          (is_long),
        .pred_pc          (pred_pc),
        .halt             (halt),
        .mem_req          (mem_req),
        .mem_addr         (mem_addr),
        .instruction      (instruction),
        .inst_valid       (inst_valid),
        .inst_pc          (inst_pc),
        .flush            (flush),
        .push             (push),
        .push_len         (push_len),
        .dec_word         (dec_word),
        .dec_pc           (dec_pc)
    );

    fetch_predecode u_predecode (
        .word    (dec_word),
        .pc      (dec_pc),
        .is_long (is_long),
        .pred_pc (pred_pc),
        .halt    (halt)
    );

    fetch_size_queue u_size_queue (
        .clk              (clk),
        .rst              (rst),
        .push             (push),
        .push_len         (push_len),
        .branch_taken     (branch_taken),
        .branch_pc        (branch_pc),
        .branch_not_taken (branch_not_taken),
        .jalr_ready       (jalr_ready),
        .jalr_addr        (jalr_addr),
        .pc_ready         (pc_ready),
        .nxt_pc           (nxt_pc),
        .commit_pc        (commit_pc),
        .fallthrough_pc   (fallthrough_pc)
    );

endmodule

`default_nettype wire

//--- fetch_size_queue.sv
`default_nettype none
`timescale 1ns/1ns

`include "fetch_macros.svh"

module fetch_size_queue
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  inst_len_t push_len,
    input  logic      branch_taken,
    input  addr_t     branch_pc,
    input  logic      branch_not_taken,
    input  logic      jalr_ready,
    input  addr_t     jalr_addr,
    input  logic      pc_ready,
    input  addr_t     nxt_pc,
    output addr_t     commit_pc,
    output addr_t     fallthrough_pc
);

    localparam int unsigned SQ_DEPTH = 1 << `FETCH_SQ_DEPTH_LOG;

    inst_len_t len_ring [SQ_DEPTH];

    sq_ptr_t                    head;
    sq_ptr_t                    tail;
    logic [`FETCH_SQ_DEPTH_LOG:0] count;
    logic                       pop;
    logic                       empty;
    logic                       full;
    inst_len_t                  head_len;

    // Every resolution strobe retires the oldest delivered instruction.
    assign pop      = branch_taken | branch_not_taken | jalr_ready | pc_ready;
    assign empty    = (count == '0);
    assign full     = count[`FETCH_SQ_DEPTH_LOG];
    assign head_len = len_ring[head];

    assign fallthrough_pc = head_len ? commit_pc + addr_t'(4) : commit_pc + addr_t'(2);

    always_ff @(posedge clk) begin
        if (push) begin
            len_ring[tail] <= push_len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            commit_pc <= '0;
        end else if (branch_not_taken) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            commit_pc <= fallthrough_pc;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (branch_taken) begin
                commit_pc <= branch_pc;
            end else if (jalr_ready) begin
                commit_pc <= jalr_addr;
            end else if (pc_ready) begin
                commit_pc <= (nxt_pc == `FETCH_NO_TARGET) ? fallthrough_pc : nxt_pc;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);

    // the back end resolves at most one instruction per cycle.
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({branch_taken, branch_not_taken, jalr_ready, pc_ready}));

endmodule

`default_nettype wire

//--- fetch_pc_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

`include "fetch_macros.svh"

module fetch_pc_ctrl
    import fetch_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      mem_valid,
    input  word_t     mem_data,
    input  logic      lsb_full,
    input  logic      iq_full,
    input  logic      jalr_ready,
    input  addr_t     jalr_addr,
    input  logic      branch_not_taken,
    input  addr_t     fallthrough_pc,
    input  inst_len_t is_long,
    input  addr_t     pred_pc,
    input  logic      halt,
    output logic      mem_req,
    output addr_t     mem_addr,
    output word_t     instruction,
    output logic      inst_valid,
    output addr_t     inst_pc,
    output logic      flush,
    output logic      push,
    output inst_len_t push_len,
    output word_t     dec_word,
    output addr_t     dec_pc
);

    fetch_state_t state;
    addr_t        fetch_pc;
    logic         drop;
    logic         stall;
    logic         issue;
    logic         deliver;

    assign stall = lsb_full | iq_full;

    // The word is predecoded in the cycle it arrives so that the next
    // fetch address is ready on the delivery edge.
    assign dec_word = mem_data;
    assign dec_pc   = fetch_pc;

    assign issue = ((state == IDLE) || (state == DELIVER)) && !stall && !branch_not_taken;

    assign deliver = (state == WAIT_MEM) && mem_valid && !drop && !branch_not_taken;

    // ==================================================
    // state machine
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            fetch_pc   <= '0;
            drop       <= 1'b0;
            mem_req    <= 1'b0;
            inst_valid <= 1'b0;
            flush      <= 1'b0;
            push       <= 1'b0;
        end else begin
            mem_req    <= issue;
            inst_valid <= deliver;
            push       <= deliver;
            flush      <= branch_not_taken;
            if (branch_not_taken) begin
                fetch_pc <= fallthrough_pc;
                // a response still on its way belongs to the wrong path.
                if ((state == WAIT_MEM) && !mem_valid) begin
                    state <= WAIT_MEM;
                    drop  <= 1'b1;
                end else begin
                    state <= IDLE;
                    drop  <= 1'b0;
                end
            end else begin
                case (state)
                    IDLE, DELIVER: begin
                        state <= issue ? WAIT_MEM : IDLE;
                    end
                    WAIT_MEM: begin
                        if (mem_valid) begin
                            drop <= 1'b0;
                            if (drop) begin
                                state <= IDLE;
                            end else begin
                                fetch_pc <= pred_pc;
                                state    <= halt ? HALT_JALR : DELIVER;
                            end
                        end
                    end
                    HALT_JALR: begin
                        if (jalr_ready) begin
                            fetch_pc <= jalr_addr;
                            state    <= IDLE;
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

    // ==================================================
    // request and delivery payload
    // ==================================================

    always_ff @(posedge clk) begin
        if (issue) begin
            mem_addr <= fetch_pc;
        end
        if (deliver) begin
            instruction <= mem_data;
            inst_pc     <= fetch_pc;
            push_len    <= is_long;
        end
    end

    // The memory only answers a request that is still outstanding.
    a_resp_outstanding: assert property (@(posedge clk) disable iff (rst)
        mem_valid |-> (state == WAIT_MEM));

endmodule

`default_nettype wire

//--- fetch_predecode.sv
`default_nettype none
`timescale 1ns/1ns

`include "fetch_macros.svh"

module fetch_predecode
    import fetch_pkg::*;
(
    input  word_t     word,
    input  addr_t     pc,
    output inst_len_t is_long,
    output addr_t     pred_pc,
    output logic      halt
);

    // ==================================================
    // opcode and funct3 encodings
    // ==================================================

    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    localparam logic [1:0] QUAD_C1 = 2'b01;
    localparam logic [1:0] QUAD_C2 = 2'b10;

    localparam logic [2:0] F3_C_JAL  = 3'b001;
    localparam logic [2:0] F3_C_J    = 3'b101;
    localparam logic [2:0] F3_C_BEQZ = 3'b110;
    localparam logic [2:0] F3_C_BNEZ = 3'b111;
    localparam logic [2:0] F3_C_JR   = 3'b100;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [1:0] quad;
    logic       c_reg_jump;

    addr_t imm_j;
    addr_t imm_b;
    addr_t imm_cj;
    addr_t imm_cb;
    addr_t seq_pc;

    assign opcode = word[6:0];
    assign funct3 = word[15:13];
    assign quad   = word[1:0];

    // Both low bits set marks a full-width instruction.
    assign is_long = &quad;
    assign seq_pc  = is_long ? pc + addr_t'(4) : pc + addr_t'(2);

    // ==================================================
    // immediates
    // ==================================================

    assign imm_j = {{(`FETCH_XLEN-20){word[31]}}, word[19:12], word[20],
                    word[30:21], 1'b0};

    assign imm_b = {{(`FETCH_XLEN-12){word[31]}}, word[7], word[30:25],
                    word[11:8], 1'b0};

    assign imm_cj = {{(`FETCH_XLEN-11){word[12]}}, word[8], word[10:9],
                     word[6], word[7], word[2], word[11], word[5:3], 1'b0};

    assign imm_cb = {{(`FETCH_XLEN-8){word[12]}}, word[6:5], word[2],
                     word[11:10], word[4:3], 1'b0};

    // C.JR and C.JALR share funct3 with C.MV and C.ADD; rs2 of zero
    // and a nonzero rs1 single out the register jumps.
    assign c_reg_jump = (quad == QUAD_C2) && (funct3 == F3_C_JR) &&
                        (word[6:2] == 5'b00000) && (word[11:7] != 5'b00000);

    // ==================================================
    // static prediction
    // ==================================================

    always_comb begin
        pred_pc = seq_pc;
        halt    = 1'b0;
        if (is_long) begin
            case (opcode)
                OP_JAL: begin
                    pred_pc = pc + imm_j;
                end
                OP_BRANCH: begin
                    // backward and forward branches alike are taken.
                    pred_pc = pc + imm_b;
                end
                OP_JALR: begin
                    halt = 1'b1;
                end
                default: begin
                    pred_pc = seq_pc;
                end
            endcase
        end else if (quad == QUAD_C1) begin
            case (funct3)
                F3_C_JAL, F3_C_J: begin
                    pred_pc = pc + imm_cj;
                end
                F3_C_BEQZ, F3_C_BNEZ: begin
                    pred_pc = pc + imm_cb;
                end
                default: begin
                    pred_pc = seq_pc;
                end
            endcase
        end else if (c_reg_jump) begin
            halt = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // ==================================================
    // datapath types
    // ==================================================

    typedef logic [`FETCH_XLEN-1:0] addr_t;
    typedef logic [`FETCH_XLEN-1:0] word_t;

    // Set for a 32-bit instruction, clear for a compressed one.
    typedef logic inst_len_t;

    typedef logic [`FETCH_SQ_DEPTH_LOG-1:0] sq_ptr_t;

    // ==================================================
    // fetch control
    // ==================================================

    typedef enum logic [1:0] {
        IDLE,
        WAIT_MEM,
        DELIVER,
        HALT_JALR
    } fetch_state_t;

endpackage

`default_nettype wire

//--- fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Width of every address and every fetched word.
`define FETCH_XLEN 32

// The length queue holds 2**FETCH_SQ_DEPTH_LOG entries.
`define FETCH_SQ_DEPTH_LOG 5

// ==================================================
// back-end encodings
// ==================================================

// An nxt_pc of all ones tells the fetch stage to fall through.
`define FETCH_NO_TARGET {`FETCH_XLEN{1'b1}}

`endif
